// ==== hw/cpuPkg.sv ====
package cpuPkg;

	// Instruction opcode, bits 15 to 14
	typedef enum logic [1:0] {
		opNop,
		opFlags,
		opJump,
		opHalt
	} opcodeT;

	// Condition code select, bits 11 to 10
	typedef enum logic [1:0] {
		ccZero,
		ccSign,
		ccParity,
		ccCarry
	} ccSelectT;

	// Jump mode, bits 13 to 12; codes 2 and 3 reserved
	typedef enum logic [1:0] {
		jmpAbs,
		jmpRel
	} jmpModeT;

	// Next PC base
	typedef enum logic {
		pcBaseA,
		pcBaseZero
	} pcBaseT;

	// Next PC offset
	typedef enum logic [1:0] {
		pcOffsetTwo,
		pcOffsetDin,
		pcOffsetZero
	} pcOffsetT;

	typedef enum logic [2:0] {
		seqFetchInstr,
		seqWaitAckLow,
		seqFetchOperand,
		seqExecute,
		seqHalted
	} seqStateT;

	typedef struct packed {
		logic zero;
		logic sign;
		logic parity;
		logic carry;
	} ccFlagsT;

	// Field positions in the instruction word
	localparam int opcodeHi = 15;
	localparam int opcodeLo = 14;
	localparam int jmpModeHi = 13;
	localparam int jmpModeLo = 12;
	localparam int ccSelectHi = 11;
	localparam int ccSelectLo = 10;
	localparam int ccInvertBit = 9;
	localparam int ccApplyBit = 8;
	localparam int flagValueHi = 7;
	localparam int flagCarryBit = 8;

	// Byte step between consecutive words
	localparam logic [15:0] wordStep = 16'd2;

endpackage

// ==== hw/branchIf.sv ====
`timescale 1ns/10ps

// Decoded jump controls from decoder to branch logic
interface branchIf
	import cpuPkg::*;
	();

	ccSelectT ccSelect;
	logic ccInvert;
	logic ccApply;
	jmpModeT jmpMode;

	modport decoder (
		output ccSelect,
		output ccInvert,
		output ccApply,
		output jmpMode
	);

	modport branch (
		input ccSelect,
		input ccInvert,
		input ccApply,
		input jmpMode
	);

endinterface

// ==== hw/instrDecoder.sv ====
`timescale 1ns/10ps

module instrDecoder
	import cpuPkg::*;
	(
	input logic [15:0] instr,
	output opcodeT opcode,
	branchIf.decoder br
);

	logic [1:0] rawMode;

	assign rawMode = instr[jmpModeHi:jmpModeLo];

	always_comb begin
		opcode = opcodeT'(instr[opcodeHi:opcodeLo]);
	end

	// Condition fields, meaningful only for jumps
	always_comb begin
		br.ccSelect = ccSelectT'(instr[ccSelectHi:ccSelectLo]);
		br.ccInvert = instr[ccInvertBit];
		br.ccApply = instr[ccApplyBit];
	end

	// Reserved mode codes fall back to absolute
	always_comb begin
		case (rawMode)
			2'b01: begin
				br.jmpMode = jmpRel;
			end
			default: begin
				br.jmpMode = jmpAbs;
			end
		endcase
	end

endmodule

// ==== hw/flagUnit.sv ====
`timescale 1ns/10ps

module flagUnit
	import cpuPkg::*;
	(
	input logic CLK,
	input logic rstN,
	input logic load,
	input logic [8:0] value,
	output ccFlagsT flags
);

	ccFlagsT nextFlags;
	logic [7:0] dataByte;

	assign dataByte = value[flagValueHi:0];

	always_comb begin
		nextFlags.zero = (dataByte == 8'h00);
		nextFlags.sign = dataByte[7];
		// Set on an even count of ones
		nextFlags.parity = ~^dataByte;
		nextFlags.carry = value[flagCarryBit];
	end

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			flags <= '0;
		end else if (load) begin
			flags <= nextFlags;
		end
	end

	// Flags only move on a flag load
	flagsHold: assert property (
		@(posedge CLK) disable iff (!rstN)
		!load |=> $stable(flags)
	) else $error("flagUnit: flags changed without load");

endmodule

// ==== hw/branchLogic.sv ====
`timescale 1ns/10ps

module branchLogic
	import cpuPkg::*;
	(
	input ccFlagsT flags,
	input logic isJump,
	branchIf.branch br,
	output pcBaseT pcBase,
	output pcOffsetT pcOffset
);

	logic selFlag;
	logic condMet;
	logic taken;

	always_comb begin
		case (br.ccSelect)
			ccZero: selFlag = flags.zero;
			ccSign: selFlag = flags.sign;
			ccParity: selFlag = flags.parity;
			default: selFlag = flags.carry;
		endcase
	end

	assign condMet = selFlag ^ br.ccInvert;

	// Apply clear means always taken
	assign taken = isJump && (!br.ccApply || condMet);

	always_comb begin
		if (taken && br.jmpMode == jmpAbs) begin
			pcBase = pcBaseZero;
			pcOffset = pcOffsetDin;
		end else if (taken) begin
			pcBase = pcBaseA;
			pcOffset = pcOffsetDin;
		end else begin
			pcBase = pcBaseA;
			pcOffset = pcOffsetTwo;
		end
		// A zero base with zero offset would restart at address 0
		noZeroTarget: assert (!(pcBase == pcBaseZero && pcOffset == pcOffsetZero))
			else $error("branchLogic: zero base with zero offset");
	end

endmodule

// ==== hw/fetchSequencer.sv ====
`timescale 1ns/10ps

module fetchSequencer
	import cpuPkg::*;
	#(
	parameter logic [15:0] resetPc = 16'h0000
) (
	input logic CLK,
	input logic rstN,
	output logic memReq,
	output logic [15:0] memAddr,
	input logic memAck,
	input logic [15:0] memData,
	output logic [15:0] instr,
	input opcodeT opcode,
	input pcBaseT pcBase,
	input pcOffsetT pcOffset,
	output logic flagLoad,
	output logic halted
);

	seqStateT state;
	logic [15:0] operand;
	logic [15:0] baseAddr;
	logic [15:0] offsetVal;
	logic [15:0] nextAddr;
	logic capture;
	opcodeT fetchedOp;

	// Word arriving on the bus, peeked to decide on an operand fetch
	assign fetchedOp = opcodeT'(memData[opcodeHi:opcodeLo]);
	assign capture = memReq && memAck;

	// memAddr still points at the last word fetched
	always_comb begin
		if (pcBase == pcBaseA) begin
			baseAddr = memAddr;
		end else begin
			baseAddr = 16'h0000;
		end
	end

	always_comb begin
		case (pcOffset)
			pcOffsetTwo: offsetVal = wordStep;
			pcOffsetDin: offsetVal = operand;
			default: offsetVal = 16'h0000;
		endcase
	end

	// Wraps at 16 bits
	assign nextAddr = baseAddr + offsetVal;

	assign flagLoad = (state == seqExecute) && (opcode == opFlags);

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			state <= seqFetchInstr;
			memReq <= 1'b0;
			memAddr <= resetPc;
			halted <= 1'b0;
		end else begin
			case (state)
				seqFetchInstr: begin
					if (!memReq) begin
						if (!memAck) begin
							memReq <= 1'b1;
						end
					end else if (memAck) begin
						memReq <= 1'b0;
						if (fetchedOp == opJump) begin
							state <= seqWaitAckLow;
						end else begin
							state <= seqExecute;
						end
					end
				end
				seqWaitAckLow: begin
					// Step to the operand once the instruction cycle closes
					if (!memAck) begin
						memAddr <= memAddr + wordStep;
						state <= seqFetchOperand;
					end
				end
				seqFetchOperand: begin
					if (!memReq) begin
						if (!memAck) begin
							memReq <= 1'b1;
						end
					end else if (memAck) begin
						memReq <= 1'b0;
						state <= seqExecute;
					end
				end
				seqExecute: begin
					if (opcode == opHalt) begin
						halted <= 1'b1;
						state <= seqHalted;
					end else begin
						memAddr <= nextAddr;
						state <= seqFetchInstr;
					end
				end
				default: begin
					// Parked until reset
					state <= seqHalted;
				end
			endcase
		end
	end

	// Captured words
	always_ff @(posedge CLK) begin
		if (capture && state == seqFetchInstr) begin
			instr <= memData;
		end
		if (capture && state == seqFetchOperand) begin
			operand <= memData;
		end
	end

	addrStable: assert property (
		@(posedge CLK) disable iff (!rstN)
		memReq |=> $stable(memAddr)
	) else $error("fetchSequencer: memAddr moved during request");

	// New request only after the previous ack dropped
	reqAfterAckLow: assert property (
		@(posedge CLK) disable iff (!rstN)
		$rose(memReq) |-> !$past(memAck)
	) else $error("fetchSequencer: memReq rose with memAck high");

endmodule

// ==== hw/fetchCore.sv ====
`timescale 1ns/10ps

module fetchCore
	import cpuPkg::*;
	#(
	parameter logic [15:0] resetPc = 16'h0000
) (
	input logic CLK,
	input logic rstN,
	output logic memReq,
	output logic [15:0] memAddr,
	input logic memAck,
	input logic [15:0] memData,
	output logic halted
);

	logic [15:0] instr;
	opcodeT opcode;
	ccFlagsT flags;
	logic flagLoad;
	pcBaseT pcBase;
	pcOffsetT pcOffset;

	branchIf brIf ();

	instrDecoder i_decoder (
		.instr(instr),
		.opcode(opcode),
		.br(brIf.decoder)
	);

	flagUnit i_flags (
		.CLK(CLK),
		.rstN(rstN),
		.load(flagLoad),
		.value(instr[flagCarryBit:0]),
		.flags(flags)
	);

	branchLogic i_branch (
		.flags(flags),
		.isJump(opcode == opJump),
		.br(brIf.branch),
		.pcBase(pcBase),
		.pcOffset(pcOffset)
	);

	fetchSequencer #(
		.resetPc(resetPc)
	) i_sequencer (
		.CLK(CLK),
		.rstN(rstN),
		.memReq(memReq),
		.memAddr(memAddr),
		.memAck(memAck),
		.memData(memData),
		.instr(instr),
		.opcode(opcode),
		.pcBase(pcBase),
		.pcOffset(pcOffset),
		.flagLoad(flagLoad),
		.halted(halted)
	);

endmodule

// ==== dv/tbMemory.sv ====
`timescale 1ns/10ps

module tbMemory #(
	parameter logic [15:0] resetPc = 16'h0020
) (
	input logic CLK,
	input logic rstN,
	input logic memReq,
	input logic [15:0] memAddr,
	output logic memAck,
	output logic [15:0] memData
);

	localparam logic [1:0] modeAbs = 2'd0;
	localparam logic [1:0] modeRel = 2'd1;

	logic [15:0] mem [0:32767];
	logic [15:0] wp;
	logic [8:0] setVal [4];
	logic [8:0] clrVal [4];
	logic [8:0] probeVal [5];
	logic armed;
	logic [1:0] delay;
	int protoErrors;

	task automatic putWord(input logic [15:0] w);
		mem[wp[15:1]] = w;
		wp = wp + 16'd2;
	endtask

	task automatic putFlags(input logic [8:0] v);
		putWord({2'b01, 5'b00000, v});
	endtask

	// Taken or not, both paths meet two words past the operand
	task automatic condJump(input logic [1:0] mode, input logic [1:0] cc, input logic inv);
		logic [15:0] opAddr;
		opAddr = wp + 16'd2;
		putWord({2'b10, mode, cc, inv, 1'b1, 8'h00});
		putWord(mode == modeAbs ? opAddr + 16'd4 : 16'd4);
		putWord(16'h0000);
	endtask

	task automatic uncondJump(input logic [1:0] mode, input logic [1:0] cc, input logic inv,
			input logic [15:0] target);
		logic [15:0] opAddr;
		opAddr = wp + 16'd2;
		putWord({2'b10, mode, cc, inv, 1'b0, 8'h00});
		putWord(mode == modeAbs ? target : target - opAddr);
		wp = target;
	endtask

	initial begin
		memAck = 1'b0;
		memData = 16'h0000;
		void'($urandom(32'ha185c02d));
		setVal = '{9'h000, 9'h080, 9'h003, 9'h100};
		clrVal = '{9'h001, 9'h001, 9'h001, 9'h000};
		probeVal = '{9'h000, 9'h080, 9'h007, 9'h003, 9'h1FF};
		// Unused words decode as halt
		for (int i = 0; i < 32768; i++) begin
			mem[i] = {2'b11, 14'(i ^ (i >> 7))};
		end
		wp = resetPc;
		repeat (6) putWord(16'h0000);
		uncondJump(modeAbs, 2'd0, 1'b0, 16'h0100);
		for (int k = 0; k < 4; k++) begin
			putFlags((k % 2 == 1) ? 9'h1FF : 9'h000);
			uncondJump(modeAbs, 2'(k), 1'b1, wp + 16'h0030);
			uncondJump(modeRel, 2'(k), 1'b0, wp + 16'h0022);
		end
		uncondJump(modeRel, 2'd0, 1'b0, 16'h0400);
		for (int cc = 0; cc < 4; cc++) begin
			putFlags(setVal[cc]);
			condJump(modeAbs, 2'(cc), 1'b0);
			condJump(modeRel, 2'(cc), 1'b1);
			putFlags(clrVal[cc]);
			condJump(modeRel, 2'(cc), 1'b0);
			condJump(modeAbs, 2'(cc), 1'b1);
		end
		uncondJump(modeAbs, 2'd0, 1'b0, 16'h0800);
		for (int p = 0; p < 5; p++) begin
			putFlags(probeVal[p]);
			for (int cc = 0; cc < 4; cc++) begin
				condJump((cc % 2 == 1) ? modeRel : modeAbs, 2'(cc), 1'b0);
			end
		end
		uncondJump(modeAbs, 2'd0, 1'b0, 16'h0C00);
		putWord(16'h0000);
		putWord(16'hC000);
	end

	always @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			memAck <= 1'b0;
			memData <= 16'h0000;
			armed <= 1'b0;
			delay <= 2'd0;
		end else if (memReq && !memAck) begin
			if (!armed) begin
				armed <= 1'b1;
				delay <= 2'($urandom % 4);
			end else if (delay == 2'd0) begin
				memAck <= 1'b1;
				memData <= mem[memAddr[15:1]];
				armed <= 1'b0;
			end else begin
				delay <= delay - 2'd1;
			end
		end else if (!memReq && memAck) begin
			// Sometimes hold ack one more cycle
			if ($urandom % 2 == 0) begin
				memAck <= 1'b0;
			end
		end
	end

	reqHeld: assert property (
		@(posedge CLK) disable iff (!rstN)
		memReq && !memAck |=> memReq
	) else begin
		protoErrors++;
		$display("memReq dropped before memAck at %0t", $time);
	end

	reqDropAfterAck: assert property (
		@(posedge CLK) disable iff (!rstN)
		$fell(memReq) |-> $past(memAck)
	) else begin
		protoErrors++;
		$display("memReq fell without a preceding memAck at %0t", $time);
	end

	addrHeld: assert property (
		@(posedge CLK) disable iff (!rstN)
		memReq |=> !memReq || $stable(memAddr)
	) else begin
		protoErrors++;
		$display("memAddr changed during a request at %0t", $time);
	end

	noReqWhileAck: assert property (
		@(posedge CLK) disable iff (!rstN)
		$rose(memReq) |-> !$past(memAck)
	) else begin
		protoErrors++;
		$display("memReq rose while memAck was still high at %0t", $time);
	end

endmodule

// ==== dv/tbFetchCore.sv ====
`timescale 1ns/10ps

module tbFetchCore;

	localparam logic [15:0] resetPc = 16'h0020;
	localparam int cycleLimit = 4000;
	localparam int numTests = 5;
	localparam int maxFetches = 400;

	logic CLK;
	logic rstN;
	logic memReq;
	logic memAck;
	logic halted;
	logic prevReq;
	logic [15:0] memAddr;
	logic [15:0] memData;
	logic [15:0] expAddr [maxFetches];
	int expTest [maxFetches];
	int expCount;
	int fetchIdx;
	int cycles;
	int passCount;
	int failCount;
	int testErrors [numTests + 1];
	bit reported [numTests + 1];
	string testNames [numTests + 1];

	fetchCore #(
		.resetPc(resetPc)
	) i_dut (
		.CLK(CLK),
		.rstN(rstN),
		.memReq(memReq),
		.memAddr(memAddr),
		.memAck(memAck),
		.memData(memData),
		.halted(halted)
	);

	tbMemory #(
		.resetPc(resetPc)
	) i_mem (
		.CLK(CLK),
		.rstN(rstN),
		.memReq(memReq),
		.memAddr(memAddr),
		.memAck(memAck),
		.memData(memData)
	);

	always #2 CLK = ~CLK;

	// Program regions of the image
	function automatic int testOf(input logic [15:0] a);
		if (a < 16'h0100) return 1;
		if (a < 16'h0400) return 2;
		if (a < 16'h0800) return 3;
		if (a < 16'h0C00) return 4;
		return 5;
	endfunction

	task automatic addExpected(input logic [15:0] a);
		expAddr[expCount] = a;
		expTest[expCount] = testOf(a);
		expCount++;
	endtask

	// Walks the image with the architectural rules
	task automatic buildExpected();
		logic [15:0] pc;
		logic [15:0] w;
		logic [15:0] opAddr;
		logic [15:0] operand;
		logic [7:0] v;
		logic fz;
		logic fs;
		logic fp;
		logic fc;
		logic sel;
		logic taken;
		bit done;
		pc = resetPc;
		{fz, fs, fp, fc} = 4'b0000;
		done = 0;
		expCount = 0;
		while (!done && expCount < maxFetches - 2) begin
			w = i_mem.mem[pc[15:1]];
			addExpected(pc);
			case (w[15:14])
				2'b11: begin
					done = 1;
				end
				2'b01: begin
					v = w[7:0];
					fz = (v == 8'h00);
					fs = v[7];
					fp = ~^v;
					fc = w[8];
					pc = pc + 16'd2;
				end
				2'b10: begin
					opAddr = pc + 16'd2;
					addExpected(opAddr);
					operand = i_mem.mem[opAddr[15:1]];
					case (w[11:10])
						2'd0: sel = fz;
						2'd1: sel = fs;
						2'd2: sel = fp;
						default: sel = fc;
					endcase
					taken = !w[8] || (sel ^ w[9]);
					if (!taken) begin
						pc = opAddr + 16'd2;
					end else if (w[13:12] == 2'b01) begin
						pc = opAddr + operand;
					end else begin
						pc = operand;
					end
				end
				default: begin
					pc = pc + 16'd2;
				end
			endcase
		end
	endtask

	task automatic reportTest(input int t);
		reported[t] = 1;
		if (testErrors[t] == 0) begin
			passCount++;
			$display("test %0d %s: passed", t, testNames[t]);
		end else begin
			failCount++;
			$display("test %0d %s: failed with %0d errors", t, testNames[t], testErrors[t]);
		end
	endtask

	task automatic addrError(input int idx, input logic [15:0] actual);
		if (idx >= expCount) begin
			testErrors[numTests]++;
			$display("fetch from %h at %0t goes past the end of the program", actual, $time);
		end else begin
			testErrors[expTest[idx]]++;
			$display("error %0t memAddr expected %h actual %h", $time, expAddr[idx], actual);
		end
	endtask

	always @(posedge CLK) begin
		prevReq <= memReq;
		if (rstN && memReq && !prevReq) begin
			if (fetchIdx > 0 && fetchIdx < expCount
					&& expTest[fetchIdx] != expTest[fetchIdx - 1]) begin
				reportTest(expTest[fetchIdx - 1]);
			end
			fetchIdx <= fetchIdx + 1;
		end
	end

	fetchAddr: assert property (
		@(posedge CLK) disable iff (!rstN)
		$rose(memReq) |-> (fetchIdx < expCount && memAddr == expAddr[fetchIdx])
	) else addrError($sampled(fetchIdx), $sampled(memAddr));

	haltQuiet: assert property (
		@(posedge CLK) disable iff (!rstN)
		halted |-> !memReq
	) else begin
		testErrors[numTests]++;
		$display("memReq raised after halt at %0t", $time);
	end

	haltAtEnd: assert property (
		@(posedge CLK) disable iff (!rstN)
		$rose(halted) |-> fetchIdx == expCount
	) else begin
		testErrors[numTests]++;
		$display("halted rose before all expected fetches at %0t", $time);
	end

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit) begin
			$display("timeout after %0d cycles, halt never reached", cycles);
			$display("Test failures found");
			$finish;
		end
	end

	initial begin
		CLK = 1'b0;
		rstN = 1'b0;
		prevReq = 1'b0;
		fetchIdx = 0;
		cycles = 0;
		passCount = 0;
		failCount = 0;
		testNames = '{"", "sequential fetch", "unconditional jumps",
			"conditional jumps", "flag computation", "halt"};
		#1;
		buildExpected();
		repeat (8) @(posedge CLK);
		rstN <= 1'b1;
		wait (halted === 1'b1);
		repeat (50) @(posedge CLK);
		endFetches: assert (fetchIdx == expCount)
			else begin
				testErrors[numTests]++;
				$display("only %0d of %0d fetches seen", fetchIdx, expCount);
			end
		for (int t = 1; t <= numTests; t++) begin
			if (!reported[t]) begin
				reportTest(t);
			end
		end
		if (i_mem.protoErrors != 0) begin
			failCount++;
			$display("handshake violations seen: %0d", i_mem.protoErrors);
		end
		$display("tests passed: %0d, failed: %0d", passCount, failCount);
		if (failCount == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== tb.f ====
hw/cpuPkg.sv
hw/branchIf.sv
hw/instrDecoder.sv
hw/flagUnit.sv
hw/branchLogic.sv
hw/fetchSequencer.sv
hw/fetchCore.sv
dv/tbMemory.sv
dv/tbFetchCore.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tbFetchCore -f tb.f -o simFetchCore || exit 1
simOut=$(./obj_dir/simFetchCore)
echo "$simOut"
echo "$simOut" | grep -qF "All tests passed!" && exit 0 || exit 1
